/* all.f */
src/dsp_pkg.sv
src/sample_divider.sv
src/adc_serial.sv
src/band_split.sv
src/sample_pipeline_top.sv
tests/clock_gen.sv
tests/adc_model.sv
tests/pipeline_chk.sv
tests/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sampling pipeline testbench with Verilator.
# The run fails if the build fails, the simulator aborts or the log reports errors.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_top -o sim_tb \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation aborted"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || echo "Simulation passed"

/* tests/tb_top.sv */
// Directed tests of the sampling pipeline
// Expected filter outputs come from a window model kept here
// Each test leaves en low and the converter queue empty when it returns

`timescale 1ns/100ps
`default_nettype none

module tb_top;

  logic        clk;
  logic        arst_n;
  logic        en;
  logic        adc_sdi;
  logic        adc_cs_n;
  logic [11:0] lp_data;
  logic signed [12:0] hp_data;
  logic        out_valid;
  logic        err;

  int errors;
  int checks;
  int seed;
  int ref_win [4];     // Newest at index 0
  int cyc;             // Cycle count for timing checks
  int rise_cyc;        // Last chip-select rise
  int last_ov;         // Last out_valid cycle or -1
  bit spacing_on;
  logic cs_prev;

  clock_gen clkgen (.clk(clk), .arst_n(arst_n));
  adc_model adc (.clk(clk), .adc_cs_n(adc_cs_n), .adc_sdi(adc_sdi));

  sample_pipeline_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .en        (en),
    .adc_sdi   (adc_sdi),
    .adc_cs_n  (adc_cs_n),
    .lp_data   (lp_data),
    .hp_data   (hp_data),
    .out_valid (out_valid),
    .err       (err)
  );

  // ==============================
  // Helpers
  // ==============================
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %0h got %0h", name, exp, act);
    end
  endtask

  // Window model with lp as floor of the mean of the last 4 good codes
  task automatic ref_update(input int code, output int lp, output int hp);
    int sum;
    sum = 0;
    for (int i = 3; i > 0; i--) begin
      ref_win[i] = ref_win[i-1];
    end
    ref_win[0] = code;
    for (int i = 0; i < 4; i++) begin
      sum += ref_win[i];
    end
    lp = sum / 4;
    hp = code - lp;
  endtask

  // Bounded wait for out_valid or err
  task automatic get_result(output bit got_valid, output bit got_err);
    got_valid = 0;
    got_err   = 0;
    for (int i = 0; i < 3 * dsp_pkg::SAMPLE_DIV; i++) begin
      @(posedge clk);
      if (out_valid || err) begin
        got_valid = out_valid;
        got_err   = err;
        break;
      end
    end
    if (!got_valid && !got_err) begin
      errors++;
      $display("Timed out waiting for out_valid or err");
    end
  endtask

  // Expect a good result for code and hand back the model's lp
  task automatic check_sample(input int code, output int lp);
    bit v;
    bit e;
    int hp;
    logic signed [12:0] exp_hp;
    get_result(v, e);
    ref_update(code, lp, hp);
    if (e) begin
      errors++;
      $display("err pulsed for a good frame, code %0h", code);
    end else if (v) begin
      exp_hp = 13'(hp);
      check_value("lp_data", 32'(lp), {20'b0, lp_data});
      check_value("hp_data", {19'b0, exp_hp}, {19'b0, hp_data});
    end
  endtask

  task automatic set_en(input logic val);
    @(posedge clk);
    en <= val;
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_reset_idle();
    int lp;
    for (int i = 0; i < 3 * dsp_pkg::SAMPLE_DIV; i++) begin
      @(posedge clk);
      if (!adc_cs_n || out_valid || err) begin
        errors++;
        $display("Activity on adc_cs_n, out_valid or err while en is low");
        break;
      end
    end
    adc.queue_code(12'd0, 0);   // Keeps the window at zeros
    set_en(1'b1);
    check_sample(0, lp);
    set_en(1'b0);
  endtask

  task automatic test_warmup();
    int codes [4];
    int exp_lp [4];
    int lp;
    codes  = '{400, 800, 1200, 1600};
    exp_lp = '{100, 300, 600, 1000};
    foreach (codes[i]) adc.queue_code(12'(codes[i]), 0);
    set_en(1'b1);
    foreach (codes[i]) begin
      check_sample(codes[i], lp);
      check_value("lp_data", 32'(exp_lp[i]), {20'b0, lp_data});
    end
    set_en(1'b0);
  endtask

  task automatic test_highpass();
    int codes [40];
    int r;
    int lp;
    codes[0] = 0;      // Extremes first
    codes[1] = 4095;
    for (int i = 2; i < 40; i++) begin
      r = $random(seed);
      codes[i] = r & 32'hfff;
    end
    foreach (codes[i]) adc.queue_code(12'(codes[i]), 0);
    set_en(1'b1);
    foreach (codes[i]) check_sample(codes[i], lp);
    set_en(1'b0);
  endtask

  task automatic test_error_frame();
    bit v;
    bit e;
    int lp;
    adc.queue_code(12'd3000, 0);
    adc.queue_code(12'd4000, 1);   // Null bit set
    adc.queue_code(12'd100, 0);
    set_en(1'b1);
    check_sample(3000, lp);
    get_result(v, e);
    if (!e || v) begin
      errors++;
      $display("Bad null bit did not give an err pulse alone");
    end
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (out_valid) begin
        errors++;
        $display("out_valid followed an error frame");
      end
    end
    check_sample(100, lp);   // Window skips the bad frame
    set_en(1'b0);
  endtask

  task automatic test_timing();
    int lp;
    int n;
    for (int i = 0; i < 4; i++) adc.queue_code(12'(300 * (i + 1)), 0);
    last_ov    = -1;
    spacing_on = 1;
    set_en(1'b1);
    for (int i = 0; i < 3; i++) check_sample(300 * (i + 1), lp);
    n = 0;
    while (adc_cs_n && n < 2 * dsp_pkg::SAMPLE_DIV) begin
      @(posedge clk);
      n++;
    end
    if (adc_cs_n) begin
      errors++;
      $display("Timed out waiting for chip select to fall");
    end
    repeat (4) @(posedge clk);
    spacing_on = 0;             // Period spacing only while en stays high
    en <= 1'b0;                 // Mid-frame
    check_sample(1200, lp);
    for (int i = 0; i < 2 * dsp_pkg::SAMPLE_DIV; i++) begin
      @(posedge clk);
      if (!adc_cs_n || out_valid || err) begin
        errors++;
        $display("Sampling continued after en fell");
        break;
      end
    end
  endtask

  // ==============================
  // Timing monitor
  // ==============================
  always @(posedge clk) begin
    if (arst_n) begin
      if (adc_cs_n && !cs_prev) rise_cyc = cyc;
      if (out_valid) begin
        if (cyc != rise_cyc + 1) begin
          errors++;
          $display("out_valid not one cycle after chip select rose");
        end
        if (spacing_on && last_ov >= 0) begin
          check_value("out_valid spacing", dsp_pkg::SAMPLE_DIV, 32'(cyc - last_ov));
        end
        last_ov = cyc;
      end
    end
    cs_prev = adc_cs_n;
    cyc++;
  end

  initial begin
    en         = 1'b0;
    errors     = 0;
    checks     = 0;
    seed       = 32'h8fbb;
    cyc        = 0;
    rise_cyc   = -10;
    last_ov    = -1;
    spacing_on = 0;
    cs_prev    = 1'b1;
    foreach (ref_win[i]) ref_win[i] = 0;
    n_wait_reset();
    test_reset_idle();
    test_warmup();
    test_highpass();
    test_error_frame();
    test_timing();
    errors += int'(uut.chk.fail_cnt);   // Bound protocol assertions
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Bounded wait for reset release
  task automatic n_wait_reset();
    int n;
    n = 0;
    while (!arst_n && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!arst_n) begin
      errors++;
      $display("Reset never released");
    end
    @(posedge clk);
  endtask

endmodule

`default_nettype wire

/* tests/pipeline_chk.sv */
// Protocol checks on the pipeline internals
// Strobe spacing, chip-select frame length, valid/error exclusivity

`timescale 1ns/100ps
`default_nettype none

module pipeline_chk (
  input logic clk,
  input logic arst_n,
  input logic sample_strobe,
  input logic adc_cs_n,
  input logic sample_valid,
  input logic sample_error
);

  int unsigned since_strobe;      // Saturating count of cycles since last strobe
  int unsigned low_cnt;           // Cycles chip select has been low
  logic        cs_q;
  int unsigned fail_cnt = 0;      // Failed assertions so far

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      since_strobe <= dsp_pkg::SAMPLE_DIV;
      low_cnt      <= 0;
      cs_q         <= 1'b1;
    end else begin
      if (sample_strobe) begin
        since_strobe <= 1;
      end else if (since_strobe < dsp_pkg::SAMPLE_DIV) begin
        since_strobe <= since_strobe + 1;
      end
      low_cnt <= adc_cs_n ? 0 : low_cnt + 1;
      cs_q    <= adc_cs_n;
    end
  end

  // ==============================
  // Assertions
  // ==============================
  strobe_spacing: assert property (@(posedge clk) disable iff (!arst_n)
    sample_strobe |-> since_strobe >= dsp_pkg::SAMPLE_DIV)
    else begin
      fail_cnt++;
      $error("sample strobes closer than SAMPLE_DIV cycles");
    end

  frame_length: assert property (@(posedge clk) disable iff (!arst_n)
    (adc_cs_n && !cs_q) |-> low_cnt == dsp_pkg::FRAME_BITS)
    else begin
      fail_cnt++;
      $error("chip select low for wrong number of cycles");
    end

  pulse_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(sample_valid && sample_error))
    else begin
      fail_cnt++;
      $error("sample_valid and sample_error high together");
    end

  strobe_idle: assert property (@(posedge clk) disable iff (!arst_n)
    sample_strobe |-> adc_cs_n)
    else begin
      fail_cnt++;
      $error("sample strobe during an active frame");
    end

endmodule

bind sample_pipeline_top pipeline_chk chk (
  .clk           (clk),
  .arst_n        (arst_n),
  .sample_strobe (sample_strobe),
  .adc_cs_n      (adc_cs_n),
  .sample_valid  (sample_valid),
  .sample_error  (sample_error)
);

`default_nettype wire

/* tests/adc_model.sv */
// Behavioural single-channel SPI converter, data out only
// Each chip-select frame takes the next queued code, or 0 when the queue is empty
// Frame bits 1..16: two lead bits, null bit, 12 data bits MSB first, one trailing bit
// sdi changes on the rising edge, one bit ahead of where the capture samples it

`timescale 1ns/100ps
`default_nettype none

module adc_model (
  input  logic clk,
  input  logic adc_cs_n,
  output logic adc_sdi
);

  logic [11:0] code_q [$];   // Pending codes
  bit          bad_q  [$];   // Null bit set for that frame

  logic [15:0] frame;        // Bit 1 at index 15
  int          low_cnt;      // Low cycles seen so far

  // Queue one conversion result
  task automatic queue_code(input logic [11:0] code, input bit bad);
    code_q.push_back(code);
    bad_q.push_back(bad);
  endtask

  initial begin
    adc_sdi = 1'b1;
    low_cnt = 0;
    frame   = '1;
  end

  always @(posedge clk) begin
    if (adc_cs_n) begin
      low_cnt = 0;
      adc_sdi <= 1'b1;          // Idle level, also bit 1
    end else begin
      low_cnt = low_cnt + 1;
      if (low_cnt == 1) begin
        if (code_q.size() > 0) begin
          frame = {2'b11, bad_q.pop_front(), code_q.pop_front(), 1'b1};
        end else begin
          frame = {2'b11, 1'b0, 12'h000, 1'b1};
        end
      end
      // Present bit low_cnt+1 for the next cycle
      if (low_cnt < 16) begin
        adc_sdi <= frame[15 - low_cnt];
      end else begin
        adc_sdi <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock period, arst_n low for the first 3 rising edges

`timescale 1ns/100ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;   // Release after 3 cycles
  end

  always #50 clk = ~clk;   // Half period

endmodule

`default_nettype wire

/* src/sample_pipeline_top.sv */
// Sampling pipeline, one clock domain
// Divider -> serial ADC capture -> lowpass / highpass split
// out_valid pulses 18 cycles after each strobe, err 17 cycles after
// No back-pressure, consumers must take every pulse

`timescale 1ns/100ps
`default_nettype none

module sample_pipeline_top (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               en,         // Sampling enable
  input  logic                               adc_sdi,    // From converter
  output logic                               adc_cs_n,   // To converter
  output logic        [dsp_pkg::SAMPLE_W-1:0] lp_data,
  output logic signed [dsp_pkg::HP_W-1:0]     hp_data,
  output logic                               out_valid,
  output logic                               err         // Bad frame pulse
);

  logic                         sample_strobe;  // Divider to ADC
  logic [dsp_pkg::SAMPLE_W-1:0] sample_data;
  logic                         sample_valid;
  logic                         sample_error;

  assign err = sample_error;   // Straight out, no extra delay

  // ==============================
  // Stages
  // ==============================
  sample_divider divider (
    .clk           (clk),
    .arst_n        (arst_n),
    .en            (en),
    .sample_strobe (sample_strobe)
  );

  adc_serial adc (
    .clk           (clk),
    .arst_n        (arst_n),
    .sample_strobe (sample_strobe),
    .adc_sdi       (adc_sdi),
    .adc_cs_n      (adc_cs_n),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .sample_error  (sample_error)
  );

  // Error frames never reach the filter window
  band_split split (
    .clk           (clk),
    .arst_n        (arst_n),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .lp_data       (lp_data),
    .hp_data       (hp_data),
    .out_valid     (out_valid)
  );

endmodule

`default_nettype wire

/* src/band_split.sv */
// Splits each accepted sample into lowpass and highpass parts
// Lowpass is a 4-tap moving average, floor of sum / AVG_TAPS
// Highpass is the new sample minus that average, signed
// Window starts at zeros, so the first outputs show warm-up
// Results register one cycle after sample_valid

`timescale 1ns/100ps
`default_nettype none

module band_split (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               sample_valid,  // New good sample
  input  logic        [dsp_pkg::SAMPLE_W-1:0] sample_data,
  output logic        [dsp_pkg::SAMPLE_W-1:0] lp_data,       // Moving average
  output logic signed [dsp_pkg::HP_W-1:0]     hp_data,       // Residue
  output logic                               out_valid
);

  // Newest sample in entry 0, oldest in the last entry
  logic [dsp_pkg::SAMPLE_W-1:0] win [dsp_pkg::AVG_TAPS];
  logic [dsp_pkg::SUM_W-1:0]    sum_q;     // Sum of the window
  logic [dsp_pkg::SUM_W-1:0]    sum_next;  // Sum with new sample in
  logic [dsp_pkg::SUM_W-1:0]    new_ext;   // New sample, sum width
  logic [dsp_pkg::SUM_W-1:0]    old_ext;   // Sample falling out

  logic        [dsp_pkg::SAMPLE_W-1:0] lp_next;
  logic signed [dsp_pkg::HP_W-1:0]     hp_next;

  // ==============================
  // Running sum
  // ==============================
  assign new_ext = {{dsp_pkg::AVG_SHIFT{1'b0}}, sample_data};
  assign old_ext = {{dsp_pkg::AVG_SHIFT{1'b0}}, win[dsp_pkg::AVG_TAPS-1]};

  // Add newest, drop oldest
  assign sum_next = sum_q + new_ext - old_ext;

  // Floor divide by shift, unsigned sum
  assign lp_next = sum_next[dsp_pkg::SUM_W-1:dsp_pkg::AVG_SHIFT];

  // Both operands zero extended, result fits HP_W
  assign hp_next = $signed({1'b0, sample_data}) - $signed({1'b0, lp_next});

  // Window only moves on good samples
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < dsp_pkg::AVG_TAPS; i++) begin
        win[i] <= '0;
      end
      sum_q <= '0;
    end else if (sample_valid) begin
      win[0] <= sample_data;
      for (int i = 1; i < dsp_pkg::AVG_TAPS; i++) begin
        win[i] <= win[i-1];   // Age the window
      end
      sum_q <= sum_next;
    end
  end

  // ==============================
  // Output registers
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sample_valid;   // Same cycle as the data below
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      lp_data <= lp_next;
      hp_data <= hp_next;
    end
  end

endmodule

`default_nettype wire

/* src/adc_serial.sv */
// Serial capture for a single-channel, data-only SPI ADC
// Serial clock is clk itself, sdi sampled on the rising edge
// Strobes that arrive while a frame is running are ignored
// On a null bit error sample_data keeps the last good code

`timescale 1ns/100ps
`default_nettype none

module adc_serial (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         sample_strobe,  // Start a conversion
  input  logic                         adc_sdi,        // Serial data from converter
  output logic                         adc_cs_n,       // Chip select, active low
  output logic [dsp_pkg::SAMPLE_W-1:0] sample_data,    // Last good code
  output logic                         sample_valid,   // Good frame pulse
  output logic                         sample_error    // Bad null bit pulse
);

  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_SHIFT = 1'b1
  } state_t;

  state_t                          state;
  logic [dsp_pkg::BIT_POS_W-1:0]   bit_pos;   // Frame position of bit on sdi
  logic                            null_bad;  // Null bit read as one
  logic [dsp_pkg::SAMPLE_W-1:0]    shift_q;   // Data bits, MSB first
  logic                            in_data;   // Current bit is a data bit
  logic                            last_bit;  // Current bit ends the frame
  logic                            shifting;

  assign shifting = (state == ST_SHIFT);
  assign last_bit = (bit_pos == dsp_pkg::POS_LAST);

  // Data sits right after the null bit, up to DATA_LAST
  assign in_data = (bit_pos > dsp_pkg::POS_NULL) && (bit_pos <= dsp_pkg::POS_DATA_LAST);

  // ==============================
  // Frame control
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= ST_IDLE;
      bit_pos      <= '0;
      null_bad     <= 1'b0;
      adc_cs_n     <= 1'b1;    // Converter deselected
      sample_valid <= 1'b0;
      sample_error <= 1'b0;
    end else begin
      // Result pulses last one cycle
      sample_valid <= 1'b0;
      sample_error <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (sample_strobe) begin
            state    <= ST_SHIFT;
            adc_cs_n <= 1'b0;    // Open frame
            bit_pos  <= dsp_pkg::BIT_POS_W'(1);
            null_bad <= 1'b0;
          end
        end

        ST_SHIFT: begin
          if (bit_pos == dsp_pkg::POS_NULL) begin
            null_bad <= adc_sdi;   // Latch null bit
          end
          if (last_bit) begin
            state        <= ST_IDLE;
            adc_cs_n     <= 1'b1;  // Close frame
            bit_pos      <= '0;
            sample_valid <= !null_bad;
            sample_error <= null_bad;
          end else begin
            bit_pos <= bit_pos + 1'b1;
          end
        end

        default: begin
          state    <= ST_IDLE;
          adc_cs_n <= 1'b1;
        end
      endcase
    end
  end

  // ==============================
  // Data path
  // ==============================
  // Shift register fills over the 12 data bits, done before the last bit
  always_ff @(posedge clk) begin
    if (shifting && in_data) begin
      shift_q <= {shift_q[dsp_pkg::SAMPLE_W-2:0], adc_sdi};
    end
    if (shifting && last_bit && !null_bad) begin
      sample_data <= shift_q;   // Only good frames update
    end
  end

endmodule

`default_nettype wire

/* src/sample_divider.sv */
// Sample strobe generator
// Counter holds at zero while en is low, so no strobes then
// First strobe comes SAMPLE_DIV cycles after en rises, then one per period
// Strobe is a registered one-cycle pulse

`timescale 1ns/100ps
`default_nettype none

module sample_divider (
  input  logic clk,
  input  logic arst_n,
  input  logic en,             // Run enable, level
  output logic sample_strobe   // One-cycle pulse per period
);

  logic [dsp_pkg::DIV_W-1:0] div_cnt;   // Clocks since last wrap
  logic                      div_wrap;  // Count at its last value

  assign div_wrap = (div_cnt == dsp_pkg::DIV_LAST);

  // ==============================
  // Period counter and strobe
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt       <= '0;
      sample_strobe <= 1'b0;
    end else if (!en) begin
      div_cnt       <= '0;    // Hold at zero while stopped
      sample_strobe <= 1'b0;
    end else begin
      sample_strobe <= div_wrap;
      if (div_wrap) begin
        div_cnt <= '0;         // Restart period
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/dsp_pkg.sv */
// Shared constants for the sampling pipeline
// Unsigned 12-bit ADC codes, fixed 16-bit serial frame
// SAMPLE_DIV must exceed FRAME_BITS + 2 so that frames never overlap
// AVG_TAPS must be a power of two

`default_nettype none

package dsp_pkg;

  // ==============================
  // Sample formats
  // ==============================
  localparam int unsigned SAMPLE_W = 12;            // ADC code width
  localparam int unsigned HP_W     = SAMPLE_W + 1;  // Signed highpass result

  // ==============================
  // Serial frame layout
  // ==============================
  localparam int unsigned FRAME_BITS = 16;              // CS low cycles per conversion
  localparam int unsigned LEAD_BITS  = 2;               // Don't-care bits up front
  localparam int unsigned NULL_POS   = LEAD_BITS + 1;   // Must read zero
  localparam int unsigned DATA_LAST  = NULL_POS + SAMPLE_W;  // LSB position

  // Frame position counter, counts 1..FRAME_BITS
  localparam int unsigned BIT_POS_W = $clog2(FRAME_BITS + 1);

  // Typed positions, saves casts at every compare
  localparam logic [BIT_POS_W-1:0] POS_NULL      = BIT_POS_W'(NULL_POS);
  localparam logic [BIT_POS_W-1:0] POS_DATA_LAST = BIT_POS_W'(DATA_LAST);
  localparam logic [BIT_POS_W-1:0] POS_LAST      = BIT_POS_W'(FRAME_BITS);

  // ==============================
  // Sample rate divider
  // ==============================
  localparam int unsigned SAMPLE_DIV = 64;  // Clocks between strobes
  localparam int unsigned DIV_W      = $clog2(SAMPLE_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);  // Wrap value

  // ==============================
  // Moving average
  // ==============================
  localparam int unsigned AVG_TAPS  = 4;
  localparam int unsigned AVG_SHIFT = $clog2(AVG_TAPS);  // Divide by shift
  localparam int unsigned SUM_W     = SAMPLE_W + AVG_SHIFT;  // Never overflows

endpackage

`default_nettype wire
